// File: all.f
hw/netstats_pkg.sv
hw/stat_bus_decoder.sv
hw/port_stats.sv
hw/stat_readback.sv
hw/netstats.sv
verification/stat_checker.sv
verification/tb_netstats.sv

// File: verification/netstats_testdata.txt
# cmd then hex fields: T test, R port len err, D addr, E addr value, W addr
# K drops cyc in mid-burst, I idle clocks
T 1
R 0 0040 0
R 0 05DC 1
R 1 0200 0
R 0 0064 0
R 3 05EE 1
I 5
E 00 00000003
E 01 00000680
E 02 00000001
E 21 00000200
E 40 00000000
E 62 00000001
T 2
E 03 00000040
E 04 000005DC
E 05 00000064
E 23 00000200
E 43 0000FFFF
E 44 00000000
T 3
W 00
I 4
E 00 00000000
E 03 0000FFFF
E 20 00000001
R 0 0050 0
I 5
E 05 00000050
T 4
E 06 00000000
E 3F 00000000
W 47
T 5
D 00
D 21
D 42
D 63
D 04
T 6
D 00
D 20
D 40
K
I 3
E 20 00000001

// File: verification/tb_netstats.sv
// Testbench top for the switch statistics block
// Clock, reset, test data reader, bus and report driver, DUT and checker

`timescale 1ns/100ps

module tb_netstats;
	import netstats_pkg::*;

	logic                        i_clk = 1'b0;
	logic                        i_rst;
	logic                        i_wb_cyc;
	logic                        i_wb_stb;
	logic                        i_wb_we;
	logic [WB_ADDR_W-1:0]        i_wb_addr;
	logic [WB_DATA_W-1:0]        i_wb_data;
	logic [WB_DATA_W/8-1:0]      i_wb_sel;
	logic                        o_wb_stall;
	logic                        o_wb_ack;
	logic [WB_DATA_W-1:0]        o_wb_data;
	pkt_report_t [NUM_PORTS-1:0] i_reports;
	// Expected read value from the test data, for the checker
	logic                        exp_valid;
	logic [WB_DATA_W-1:0]        exp_data;

	// Burst bookkeeping
	int issued;
	int acks_seen;
	int cur_test;
	int seed = 80;

	// 100 ns clock
	always #50 i_clk = ~i_clk;

	netstats dut_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_addr  (i_wb_addr),
		.i_wb_data  (i_wb_data),
		.i_wb_sel   (i_wb_sel),
		.o_wb_stall (o_wb_stall),
		.o_wb_ack   (o_wb_ack),
		.o_wb_data  (o_wb_data),
		.i_reports  (i_reports)
	);

	stat_checker chk_i (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		.i_wb_stall  (o_wb_stall),
		.i_wb_ack    (o_wb_ack),
		.i_wb_data   (o_wb_data),
		.i_reports   (i_reports),
		.i_exp_valid (exp_valid),
		.i_exp_data  (exp_data)
	);

	task abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$finish;
	endtask

	// One clock, counting acks of the open burst
	task step();
		@(posedge i_clk);
		if (i_wb_cyc && o_wb_ack)
			acks_seen++;
	endtask

	task idle(input int n);
		for (int i = 0; i < n; i++)
			step();
	endtask

	task issue_access(input logic we, input logic [31:0] addr,
		input logic has_exp, input logic [31:0] exp);
		step();
		i_wb_cyc  <= 1'b1;
		i_wb_stb  <= 1'b1;
		i_wb_we   <= we;
		i_wb_addr <= addr[WB_ADDR_W-1:0];
		exp_valid <= has_exp;
		exp_data  <= exp;
		issued++;
	endtask

	// Stop issuing, wait for every ack, then release the bus
	task end_burst();
		int waited;
		if (issued != 0)
		begin
			step();
			i_wb_stb  <= 1'b0;
			exp_valid <= 1'b0;
			waited = 0;
			while (acks_seen < issued && waited < 20)
			begin
				step();
				waited++;
			end
			if (acks_seen < issued)
				abort_run("timed out waiting for a bus ack");
			else
			begin
				i_wb_cyc <= 1'b0;
				issued = 0;
				acks_seen = 0;
			end
		end
	endtask

	// Abort with requests still in flight
	task drop_cyc();
		step();
		i_wb_cyc  <= 1'b0;
		i_wb_stb  <= 1'b0;
		exp_valid <= 1'b0;
		issued = 0;
		acks_seen = 0;
	endtask

	task send_report(input logic [31:0] port, input logic [31:0] len, input logic [31:0] err);
		pkt_report_t rep;
		rep.valid = 1'b1;
		rep.err   = err[0];
		rep.len   = len[LEN_W-1:0];
		step();
		i_reports[port] <= rep;
		step();
		i_reports[port] <= '0;
		// Random gap up to two clocks
		idle($urandom % 3);
	endtask

	task close_current();
		end_burst();
		if (cur_test != 0)
		begin
			@(negedge i_clk);
			chk_i.close_test(cur_test);
		end
	endtask

	task run_line(input byte cmd, input logic [31:0] f1, input logic [31:0] f2,
		input logic [31:0] f3);
		case (cmd)
			"T":
			begin
				close_current();
				cur_test = f1;
			end
			"R":
			begin
				end_burst();
				send_report(f1, f2, f3);
			end
			"I":
			begin
				end_burst();
				idle(f1);
			end
			"D": issue_access(1'b0, f1, 1'b0, '0);
			"E": issue_access(1'b0, f1, 1'b1, f2);
			"W": issue_access(1'b1, f1, 1'b0, '0);
			"K": drop_cyc();
			default: abort_run("unknown command in the test data file");
		endcase
	endtask

	task run_file();
		int          fd;
		int          lines;
		int          cnt;
		string       line;
		byte         cmd;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		fd = $fopen("verification/netstats_testdata.txt", "r");
		if (fd == 0)
			abort_run("cannot open the test data file");
		else
		begin
			lines = 0;
			while (!$feof(fd) && lines < 1000)
			begin
				lines++;
				line = "";
				cnt = $fgets(line, fd);
				// Skip blank and comment lines
				if (cnt > 1 && line[0] != "#")
				begin
					cnt = $sscanf(line, "%c %h %h %h", cmd, f1, f2, f3);
					run_line(cmd, f1, f2, f3);
				end
			end
			if (!$feof(fd))
				abort_run("test data file did not end within 1000 lines");
			else
				$fclose(fd);
		end
	endtask

	initial
	begin
		i_rst     = 1'b1;
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_wb_sel  = '0;
		i_reports = '0;
		exp_valid = 1'b0;
		exp_data  = '0;
		issued    = 0;
		acks_seen = 0;
		cur_test  = 0;
		void'($urandom(seed));
		// Reset for 16 clocks
		for (int i = 0; i < 16; i++)
			@(posedge i_clk);
		i_rst <= 1'b0;
		run_file();
		close_current();
		idle(4);
		@(negedge i_clk);
		chk_i.report_totals();
		if (chk_i.total_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: verification/stat_checker.sv
// Bus and report monitor for the statistics block
// Reference model of every port, in-order ack comparison, result report

`timescale 1ns/100ps

module stat_checker (
	input logic                                    i_clk,
	input logic                                    i_rst,
	input logic                                    i_wb_cyc,
	input logic                                    i_wb_stb,
	input logic                                    i_wb_we,
	input logic [netstats_pkg::WB_ADDR_W-1:0]      i_wb_addr,
	input logic                                    i_wb_stall,
	input logic                                    i_wb_ack,
	input logic [netstats_pkg::WB_DATA_W-1:0]      i_wb_data,
	input netstats_pkg::pkt_report_t [netstats_pkg::NUM_PORTS-1:0] i_reports,
	// Value from the test data line, if it carried one
	input logic                                    i_exp_valid,
	input logic [netstats_pkg::WB_DATA_W-1:0]      i_exp_data
);
	import netstats_pkg::*;

	// One accepted request waiting for its ack
	typedef struct packed {
		stat_req_t            req;
		logic [WB_DATA_W-1:0] model;
		logic                 has_file;
		logic [WB_DATA_W-1:0] file;
		logic [31:0]          cycle;
	} pend_t;

	// Model of every port
	logic [WB_DATA_W-1:0] m_pkts [NUM_PORTS];
	logic [WB_DATA_W-1:0] m_bytes [NUM_PORTS];
	logic [WB_DATA_W-1:0] m_errs [NUM_PORTS];
	logic [LEN_W-1:0]     m_min [NUM_PORTS];
	logic [LEN_W-1:0]     m_max [NUM_PORTS];
	logic [LEN_W-1:0]     m_last [NUM_PORTS];
	// Clear taken last edge, lands on this one
	logic [NUM_PORTS-1:0] clr_pend;
	// Cyc as sampled on the previous edge
	logic                 prev_cyc;

	pend_t q[$];
	int    cycle;
	int    test_checks = 0;
	int    test_errs = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	int    total_checks = 0;
	int    total_errs = 0;

	task automatic clear_port(input int p);
		m_pkts[p]  = '0;
		m_bytes[p] = '0;
		m_errs[p]  = '0;
		m_min[p]   = MIN_LEN_INIT;
		m_max[p]   = '0;
		m_last[p]  = '0;
	endtask

	// Counters stick at all ones
	task automatic add_report(input int p, input pkt_report_t r);
		logic [WB_DATA_W:0] sum;
		sum = {1'b0, m_bytes[p]} + r.len;
		m_bytes[p] = sum[WB_DATA_W] ? '1 : sum[WB_DATA_W-1:0];
		if (m_pkts[p] != '1)
			m_pkts[p] = m_pkts[p] + 1;
		if (r.err && m_errs[p] != '1)
			m_errs[p] = m_errs[p] + 1;
		if (r.len < m_min[p])
			m_min[p] = r.len;
		if (r.len > m_max[p])
			m_max[p] = r.len;
		m_last[p] = r.len;
	endtask

	// Writes and unmapped indices answer zero
	function automatic logic [WB_DATA_W-1:0] model_read(input stat_req_t r);
		if (r.we)
			return '0;
		case (r.reg_idx)
			STAT_PKTS:    return m_pkts[r.port];
			STAT_BYTES:   return m_bytes[r.port];
			STAT_ERRS:    return m_errs[r.port];
			STAT_MINLEN:  return m_min[r.port];
			STAT_MAXLEN:  return m_max[r.port];
			STAT_LASTLEN: return m_last[r.port];
			default:      return '0;
		endcase
	endfunction

	task automatic take_request();
		pend_t e;
		e.req.valid   = 1'b1;
		e.req.we      = i_wb_we;
		e.req.reg_idx = stat_reg_e'(i_wb_addr[REG_IDX_W-1:0]);
		e.req.port    = i_wb_addr[WB_ADDR_W-1:REG_IDX_W];
		e.model       = model_read(e.req);
		e.has_file    = i_exp_valid;
		e.file        = i_exp_data;
		e.cycle       = cycle;
		if (i_wb_we && e.req.reg_idx == STAT_PKTS)
			clr_pend[e.req.port] = 1'b1;
		q.push_back(e);
	endtask

	task automatic check_ack();
		pend_t e;
		if (q.size() == 0)
		begin
			$display("ack arrived with no request outstanding");
			test_errs++;
			return;
		end
		e = q.pop_front();
		test_checks++;
		// Three edges from taking the request to seeing its ack
		if (cycle - e.cycle != 3)
		begin
			$display("ack for address %h came %0d clocks after its request, not 3",
				{e.req.port, e.req.reg_idx}, cycle - e.cycle);
			test_errs++;
		end
		if (i_wb_data !== e.model)
		begin
			$display("Error: o_wb_data at address %h, expected %h, got %h",
				{e.req.port, e.req.reg_idx}, e.model, i_wb_data);
			test_errs++;
		end
		if (e.has_file && e.file !== e.model)
		begin
			$display("Error: testdata value at address %h, model %h, file %h",
				{e.req.port, e.req.reg_idx}, e.model, e.file);
			test_errs++;
		end
	endtask

	task automatic close_test(input int num);
		tests_run++;
		total_checks += test_checks;
		total_errs += test_errs;
		if (test_errs != 0)
			tests_bad++;
		$display("test %0d %s: %0d checks, %0d errors", num,
			(test_errs != 0) ? "failed" : "ok", test_checks, test_errs);
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic report_totals();
		// Anything seen after the last test closed
		total_errs += test_errs;
		if (q.size() != 0)
		begin
			$display("%0d requests never got an ack", q.size());
			total_errs++;
		end
		$display("totals: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_bad, total_checks, total_errs);
	endtask

	//////////////////////////////////////////////////
	// Monitor
	//////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (i_rst)
		begin
			for (int p = 0; p < NUM_PORTS; p++)
				clear_port(p);
			clr_pend = '0;
			prev_cyc = 1'b0;
			q.delete();
			cycle = 0;
		end
		else
		begin
			cycle++;
			// Slave never stalls
			if (i_wb_stall !== 1'b0)
			begin
				$display("Error: o_wb_stall expected %h, got %h", 1'b0, i_wb_stall);
				test_errs++;
			end
			// Acks stop one clock after cyc drops
			if (!prev_cyc && i_wb_ack)
			begin
				$display("ack returned after cyc had been dropped");
				test_errs++;
			end
			// Dropped cyc kills everything in flight
			if (!i_wb_cyc)
				q.delete();
			else if (i_wb_ack)
				check_ack();
			// Clear beats a report on the same edge
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (clr_pend[p])
					clear_port(p);
				else if (i_reports[p].valid)
					add_report(p, i_reports[p]);
			end
			clr_pend = '0;
			if (i_wb_cyc && i_wb_stb)
				take_request();
			prev_cyc = i_wb_cyc;
		end
	end

endmodule

// File: hw/netstats.sv
// Top level of the four-port switch statistics block
// Bus decoder, one statistics engine per port, readback merger

`timescale 1ns/100ps

module netstats (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	// Pipelined Wishbone slave
	input  logic                                  i_wb_cyc,
	input  logic                                  i_wb_stb,
	input  logic                                  i_wb_we,
	input  logic [netstats_pkg::WB_ADDR_W-1:0]    i_wb_addr,
	input  logic [netstats_pkg::WB_DATA_W-1:0]    i_wb_data,
	input  logic [netstats_pkg::WB_DATA_W/8-1:0]  i_wb_sel,
	output logic                                  o_wb_stall,
	output logic                                  o_wb_ack,
	output logic [netstats_pkg::WB_DATA_W-1:0]    o_wb_data,
	// One packet report per port
	input  netstats_pkg::pkt_report_t [netstats_pkg::NUM_PORTS-1:0] i_reports
);
	import netstats_pkg::*;

	// Write data and byte selects carry nothing, a write only clears

	stat_req_t                            req;
	logic                                 null_ack;
	logic [NUM_PORTS-1:0]                 acks;
	logic [NUM_PORTS-1:0][WB_DATA_W-1:0]  data;

	// Never stalls, one request per clock
	assign o_wb_stall = 1'b0;

	stat_bus_decoder decoder_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_addr  (i_wb_addr),
		.o_req      (req),
		.o_null_ack (null_ack)
	);

	//////////////////////////////////////////////////
	// Per-port engines
	//////////////////////////////////////////////////

	// Same request to all, each picks out its own port
	for (genvar gi = 0; gi < NUM_PORTS; gi++)
	begin : g_port
		port_stats stats_i (
			.i_clk     (i_clk),
			.i_rst     (i_rst),
			.i_wb_cyc  (i_wb_cyc),
			.i_port_id (2'(gi)),
			.i_req     (req),
			.i_report  (i_reports[gi]),
			.o_ack     (acks[gi]),
			.o_data    (data[gi])
		);
	end

	stat_readback readback_i (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_wb_cyc   (i_wb_cyc),
		.i_acks     (acks),
		.i_data     (data),
		.i_null_ack (null_ack),
		.o_wb_ack   (o_wb_ack),
		.o_wb_data  (o_wb_data)
	);

endmodule

// File: hw/stat_readback.sv
// Response stage of the statistics block
// ORs engine acks and data into the registered Wishbone response

`timescale 1ns/100ps

module stat_readback (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_wb_cyc,
	input  logic [netstats_pkg::NUM_PORTS-1:0]    i_acks,
	input  logic [netstats_pkg::NUM_PORTS-1:0][netstats_pkg::WB_DATA_W-1:0] i_data,
	input  logic                                  i_null_ack,
	output logic                                  o_wb_ack,
	output logic [netstats_pkg::WB_DATA_W-1:0]    o_wb_data
);
	import netstats_pkg::*;

	// At most one source acks per clock
	logic                 any_ack;
	logic [WB_DATA_W-1:0] merged;

	assign any_ack = (|i_acks) || i_null_ack;

	// OR of the acking engines' data
	always_comb
	begin
		merged = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (i_acks[p])
				merged = merged | i_data[p];
		end
	end

	//////////////////////////////////////////////////
	// Bus response
	//////////////////////////////////////////////////

	// Null acks carry zero data, nothing to add
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_wb_cyc)
		begin
			o_wb_ack  <= 1'b0;
			o_wb_data <= '0;
		end
		else
		begin
			o_wb_ack  <= any_ack;
			o_wb_data <= merged;
		end
	end

endmodule

// File: hw/port_stats.sv
// Statistics engine for one switch port
// Saturating packet, byte and error counters, length tracking, clear, readback

`timescale 1ns/100ps

module port_stats (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_wb_cyc,
	input  logic [1:0]                         i_port_id,
	input  netstats_pkg::stat_req_t            i_req,
	input  netstats_pkg::pkt_report_t          i_report,
	output logic                               o_ack,
	output logic [netstats_pkg::WB_DATA_W-1:0] o_data
);
	import netstats_pkg::*;

	// Request addressed to this port, dropped along with cyc
	logic hit;
	// Any write to the packet count clears the whole port
	logic clr;

	// Counters
	logic [WB_DATA_W-1:0] r_pkts;
	logic [WB_DATA_W-1:0] r_bytes;
	logic [WB_DATA_W-1:0] r_errs;
	// Byte sum one bit wider, top bit flags overflow
	logic [WB_DATA_W:0]   byte_sum;

	// Length tracking
	logic [LEN_W-1:0] r_minlen;
	logic [LEN_W-1:0] r_maxlen;
	logic [LEN_W-1:0] r_lastlen;

	// Read mux output and its register
	logic [WB_DATA_W-1:0] rd_val;
	logic [WB_DATA_W-1:0] r_data;

	assign hit = i_req.valid && i_wb_cyc && (i_req.port == i_port_id);
	assign clr = hit && i_req.we && (i_req.reg_idx == STAT_PKTS);

	assign byte_sum = {1'b0, r_bytes}
		+ {{(WB_DATA_W + 1 - LEN_W){1'b0}}, i_report.len};

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	// Clear beats a report on the same clock
	always_ff @(posedge i_clk)
	begin
		if (i_rst || clr)
		begin
			r_pkts  <= '0;
			r_bytes <= '0;
			r_errs  <= '0;
		end
		else if (i_report.valid)
		begin
			// Each counter sticks at all ones
			if (r_pkts != '1)
				r_pkts <= r_pkts + 1'b1;
			if (byte_sum[WB_DATA_W])
				r_bytes <= '1;
			else
				r_bytes <= byte_sum[WB_DATA_W-1:0];
			if (i_report.err && (r_errs != '1))
				r_errs <= r_errs + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Lengths
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst || clr)
		begin
			r_minlen  <= MIN_LEN_INIT;
			r_maxlen  <= '0;
			r_lastlen <= '0;
		end
		else if (i_report.valid)
		begin
			if (i_report.len < r_minlen)
				r_minlen <= i_report.len;
			if (i_report.len > r_maxlen)
				r_maxlen <= i_report.len;
			r_lastlen <= i_report.len;
		end
	end

	//////////////////////////////////////////////////
	// Register read
	//////////////////////////////////////////////////

	// Lengths zero-extended to the bus width
	always_comb
	begin
		case (i_req.reg_idx)
			STAT_PKTS:    rd_val = r_pkts;
			STAT_BYTES:   rd_val = r_bytes;
			STAT_ERRS:    rd_val = r_errs;
			STAT_MINLEN:  rd_val = {{(WB_DATA_W - LEN_W){1'b0}}, r_minlen};
			STAT_MAXLEN:  rd_val = {{(WB_DATA_W - LEN_W){1'b0}}, r_maxlen};
			STAT_LASTLEN: rd_val = {{(WB_DATA_W - LEN_W){1'b0}}, r_lastlen};
			default:      rd_val = '0;
		endcase
	end

	// One cycle from request to ack
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_wb_cyc)
			o_ack <= 1'b0;
		else
			o_ack <= hit;
	end

	// Writes answer with zero
	always_ff @(posedge i_clk)
	begin
		if (hit)
			r_data <= i_req.we ? '0 : rd_val;
	end

	// Zero unless acking, so the merger can simply OR
	assign o_data = o_ack ? r_data : '0;

endmodule

// File: hw/stat_bus_decoder.sv
// Wishbone request stage of the statistics block
// Splits the address into port and register, flags unmapped indices

`timescale 1ns/100ps

module stat_bus_decoder (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  logic                            i_wb_cyc,
	input  logic                            i_wb_stb,
	input  logic                            i_wb_we,
	input  logic [netstats_pkg::WB_ADDR_W-1:0] i_wb_addr,
	output netstats_pkg::stat_req_t         o_req,
	output logic                            o_null_ack
);
	import netstats_pkg::*;

	// Request taken on any clock with cyc and stb both high
	logic      accept;
	// Register index falls inside the map
	logic      mapped;
	stat_reg_e addr_idx;

	// Registered request fields
	logic       r_valid;
	logic       r_we;
	stat_reg_e  r_idx;
	logic [1:0] r_port;

	// Unmapped request waiting one more cycle
	logic r_null_pend;

	assign accept   = i_wb_cyc && i_wb_stb;
	assign addr_idx = stat_reg_e'(i_wb_addr[REG_IDX_W-1:0]);
	assign mapped   = (addr_idx <= STAT_LASTLEN);

	//////////////////////////////////////////////////
	// Request stage
	//////////////////////////////////////////////////

	// Valid only for mapped requests, dropped with cyc
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_wb_cyc)
			r_valid <= 1'b0;
		else
			r_valid <= accept && mapped;
	end

	// Payload, meaningful only while valid
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			r_we   <= i_wb_we;
			r_idx  <= addr_idx;
			r_port <= i_wb_addr[WB_ADDR_W-1:REG_IDX_W];
		end
	end

	//////////////////////////////////////////////////
	// Null ack path
	//////////////////////////////////////////////////

	// Two stages, so it lands on the same clock as an engine ack
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_wb_cyc)
		begin
			r_null_pend <= 1'b0;
			o_null_ack  <= 1'b0;
		end
		else
		begin
			r_null_pend <= accept && !mapped;
			o_null_ack  <= r_null_pend;
		end
	end

	// Broadcast to all engines
	assign o_req.valid   = r_valid;
	assign o_req.we      = r_we;
	assign o_req.reg_idx = r_idx;
	assign o_req.port    = r_port;

endmodule

// File: hw/netstats_pkg.sv
// Shared sizes for the switch statistics block
// Register index enum, decoded bus request and packet report structs

package netstats_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////

	// Switch ports served by the block
	localparam int NUM_PORTS = 4;

	// Word address: top two bits pick the port, low five the register
	localparam int WB_ADDR_W = 7;
	localparam int REG_IDX_W = 5;

	// Bus data width
	localparam int WB_DATA_W = 32;

	// Packet length as reported by a port
	localparam int LEN_W = 16;

	// Shortest length starts at the top so the first packet always wins
	localparam logic [LEN_W-1:0] MIN_LEN_INIT = '1;

	//////////////////////////////////////////////////
	// Register map within one port
	//////////////////////////////////////////////////

	// Indices 6 to 31 are unmapped and read as zero
	typedef enum logic [REG_IDX_W-1:0] {
		STAT_PKTS    = 5'd0,
		STAT_BYTES   = 5'd1,
		STAT_ERRS    = 5'd2,
		STAT_MINLEN  = 5'd3,
		STAT_MAXLEN  = 5'd4,
		STAT_LASTLEN = 5'd5
	} stat_reg_e;

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////

	// One decoded bus request, broadcast to every engine
	typedef struct packed {
		logic      valid;
		logic      we;
		stat_reg_e reg_idx;
		// Target engine
		logic [1:0] port;
	} stat_req_t;

	// One finished packet from a port
	typedef struct packed {
		logic             valid;
		// Packet ended with an error
		logic             err;
		logic [LEN_W-1:0] len;
	} pkt_report_t;

endpackage
